// File: source/rv32_pkg.sv
// Reduced RV32I subset only; no byte/halfword access, shifts, CSRs or traps
`default_nettype none

package rv32_pkg;

    // Word and register index widths
    localparam int xlen = 32;
    localparam int reg_id_bits = 5;

    // First fetch address
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // Major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // ALU functions, PASS_B forwards the U immediate for LUI
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // What an instruction does in the later stages
    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH_EQ,
        KIND_BRANCH_NE,
        KIND_JUMP
    } kind_t;

endpackage

`default_nettype wire

// File: source/rv32_register_file.sv
// x0 is hardwired to zero; a same-cycle write is bypassed to both read ports
`timescale 1ns/1ps
`default_nettype none

module rv32_register_file (
    input  wire                               clk,
    input  wire                               resetn,
    input  wire  [rv32_pkg::reg_id_bits-1:0] rs1,
    input  wire  [rv32_pkg::reg_id_bits-1:0] rs2,
    output logic [rv32_pkg::xlen-1:0]        reg1,
    output logic [rv32_pkg::xlen-1:0]        reg2,
    input  wire                               write,
    input  wire  [rv32_pkg::reg_id_bits-1:0] rd,
    input  wire  [rv32_pkg::xlen-1:0]        wdata
);

    // Only x1..x31 are storage
    logic [rv32_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Writeback data wins over the stored value
    assign reg1 = (rs1 == '0) ? '0 : (write && rd == rs1) ? wdata : regs[rs1];
    assign reg2 = (rs2 == '0) ? '0 : (write && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

// File: source/rv32_fetch_stage.sv
// One instruction read in flight; a word returned during hold waits in a skid register
`timescale 1ns/1ps
`default_nettype none

module rv32_fetch_stage (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire  [rv32_pkg::xlen-1:0] pc,
    input  wire                        hold,
    input  wire                        flush,
    output logic [rv32_pkg::xlen-1:0] instr_addr,
    output logic                       instr_read,
    input  wire                        instr_done,
    input  wire  [rv32_pkg::xlen-1:0] instr,
    output logic                       fetch_stall,
    output logic                       f_valid,
    output logic [rv32_pkg::xlen-1:0] f_pc,
    output logic [rv32_pkg::xlen-1:0] f_instr
);

    logic                      run;
    logic                      busy;
    logic                      drop;
    logic                      have;
    logic [rv32_pkg::xlen-1:0] req_addr;
    logic [rv32_pkg::xlen-1:0] skid;
    logic                      avail;

    // Address is frozen once the request is out
    assign instr_addr = busy ? req_addr : pc;
    assign instr_read = run && !have;
    // Good word this cycle, either returning now or parked
    assign avail = (busy && instr_done && !drop) || have;
    assign fetch_stall = !avail;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            run <= 1'b0;
            busy <= 1'b0;
            drop <= 1'b0;
            have <= 1'b0;
            f_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (instr_done) begin
                busy <= 1'b0;
            end else if (instr_read) begin
                busy <= 1'b1;
            end
            if (instr_read && !busy) begin
                req_addr <= pc;
            end
            // Word in flight belongs to the old path
            if (instr_done) begin
                drop <= 1'b0;
            end else if (flush && instr_read) begin
                drop <= 1'b1;
            end
            if (flush) begin
                f_valid <= 1'b0;
                have <= 1'b0;
            end else if (!hold) begin
                f_valid <= avail;
                have <= 1'b0;
                if (avail) begin
                    f_pc <= req_addr;
                    f_instr <= have ? skid : instr;
                end
            end else if (avail && !have) begin
                // Decode frozen, park the word
                have <= 1'b1;
                skid <= instr;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rv32_decode_stage.sv
// Unsupported encodings become bubbles; load-use stalls one cycle against the exec input
`timescale 1ns/1ps
`default_nettype none

module rv32_decode_stage (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              hold,
    input  wire                              flush,
    input  wire                              f_valid,
    input  wire  [rv32_pkg::xlen-1:0]        f_pc,
    input  wire  [rv32_pkg::xlen-1:0]        f_instr,
    output logic [rv32_pkg::reg_id_bits-1:0] rs1,
    output logic [rv32_pkg::reg_id_bits-1:0] rs2,
    input  wire  [rv32_pkg::xlen-1:0]        reg1,
    input  wire  [rv32_pkg::xlen-1:0]        reg2,
    output logic                             dec_stall,
    output logic                             d_valid,
    output logic [rv32_pkg::xlen-1:0]        d_pc,
    output rv32_pkg::kind_t                  d_kind,
    output rv32_pkg::alu_op_t                d_alu_op,
    output logic [rv32_pkg::reg_id_bits-1:0] d_rs1,
    output logic [rv32_pkg::reg_id_bits-1:0] d_rs2,
    output logic [rv32_pkg::reg_id_bits-1:0] d_rd,
    output logic [rv32_pkg::xlen-1:0]        d_a,
    output logic [rv32_pkg::xlen-1:0]        d_b,
    output logic [rv32_pkg::xlen-1:0]        d_imm
);

    rv32_pkg::opcode_t   opcode;
    rv32_pkg::kind_t     kind;
    rv32_pkg::alu_op_t   alu_op;
    logic [2:0]          funct3;
    logic                use_rs1;
    logic                use_rs2;
    logic                has_rd;
    logic [rv32_pkg::xlen-1:0] imm;

    assign funct3 = f_instr[14:12];
    assign rs1 = f_instr[19:15];
    assign rs2 = f_instr[24:20];

    always_comb begin
        opcode = rv32_pkg::opcode_t'(f_instr[6:0]);
        kind = rv32_pkg::KIND_NONE;
        alu_op = rv32_pkg::ALU_ADD;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        has_rd = 1'b0;
        // I-type by default
        imm = {{20{f_instr[31]}}, f_instr[31:20]};
        case (opcode)
            rv32_pkg::OPC_OP: begin
                kind = rv32_pkg::KIND_ALU;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                has_rd = 1'b1;
                case (funct3)
                    3'b000: alu_op = f_instr[30] ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
                    3'b111: alu_op = rv32_pkg::ALU_AND;
                    3'b110: alu_op = rv32_pkg::ALU_OR;
                    3'b100: alu_op = rv32_pkg::ALU_XOR;
                    3'b010: alu_op = rv32_pkg::ALU_SLT;
                    default: kind = rv32_pkg::KIND_NONE;
                endcase
            end
            rv32_pkg::OPC_OP_IMM: begin
                // ADDI only
                kind = (funct3 == 3'b000) ? rv32_pkg::KIND_ALU : rv32_pkg::KIND_NONE;
                use_rs1 = 1'b1;
                has_rd = 1'b1;
            end
            rv32_pkg::OPC_LUI: begin
                kind = rv32_pkg::KIND_ALU;
                alu_op = rv32_pkg::ALU_PASS_B;
                has_rd = 1'b1;
                imm = {f_instr[31:12], 12'b0};
            end
            rv32_pkg::OPC_LOAD: begin
                // LW only
                kind = (funct3 == 3'b010) ? rv32_pkg::KIND_LOAD : rv32_pkg::KIND_NONE;
                use_rs1 = 1'b1;
                has_rd = 1'b1;
            end
            rv32_pkg::OPC_STORE: begin
                kind = (funct3 == 3'b010) ? rv32_pkg::KIND_STORE : rv32_pkg::KIND_NONE;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = {{20{f_instr[31]}}, f_instr[31:25], f_instr[11:7]};
            end
            rv32_pkg::OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    kind = rv32_pkg::KIND_BRANCH_EQ;
                end else if (funct3 == 3'b001) begin
                    kind = rv32_pkg::KIND_BRANCH_NE;
                end
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = {{19{f_instr[31]}}, f_instr[31], f_instr[7], f_instr[30:25],
                       f_instr[11:8], 1'b0};
            end
            rv32_pkg::OPC_JAL: begin
                kind = rv32_pkg::KIND_JUMP;
                has_rd = 1'b1;
                imm = {{11{f_instr[31]}}, f_instr[31], f_instr[19:12], f_instr[20],
                       f_instr[30:21], 1'b0};
            end
            default: kind = rv32_pkg::KIND_NONE;
        endcase
    end

    // Load still in exec, its data is not there in time for us
    assign dec_stall = f_valid && kind != rv32_pkg::KIND_NONE && d_valid
        && d_kind == rv32_pkg::KIND_LOAD && d_rd != '0
        && ((use_rs1 && rs1 == d_rd) || (use_rs2 && rs2 == d_rd));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            d_valid <= 1'b0;
        end else if (flush || (!hold && dec_stall)) begin
            d_valid <= 1'b0;
        end else if (!hold) begin
            d_valid <= f_valid && kind != rv32_pkg::KIND_NONE;
            d_pc <= f_pc;
            d_kind <= kind;
            d_alu_op <= alu_op;
            // Unused sources read as x0 so forwarding never hits
            d_rs1 <= use_rs1 ? rs1 : '0;
            d_rs2 <= use_rs2 ? rs2 : '0;
            d_rd <= has_rd ? f_instr[11:7] : '0;
            d_a <= reg1;
            d_b <= use_rs2 ? reg2 : imm;
            d_imm <= imm;
        end
    end

endmodule

`default_nettype wire

// File: source/rv32_exec_stage.sv
// Jumps resolve here, so a taken branch costs the two younger instructions
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_stage (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              hold,
    input  wire                              d_valid,
    input  wire  [rv32_pkg::xlen-1:0]        d_pc,
    input  var   rv32_pkg::kind_t            d_kind,
    input  var   rv32_pkg::alu_op_t          d_alu_op,
    input  wire  [rv32_pkg::reg_id_bits-1:0] d_rs1,
    input  wire  [rv32_pkg::reg_id_bits-1:0] d_rs2,
    input  wire  [rv32_pkg::reg_id_bits-1:0] d_rd,
    input  wire  [rv32_pkg::xlen-1:0]        d_a,
    input  wire  [rv32_pkg::xlen-1:0]        d_b,
    input  wire  [rv32_pkg::xlen-1:0]        d_imm,
    input  wire                              wb_valid,
    input  wire  [rv32_pkg::reg_id_bits-1:0] wb_rd,
    input  wire  [rv32_pkg::xlen-1:0]        wb_data,
    output logic                             take_jump,
    output logic [rv32_pkg::xlen-1:0]        jump_addr,
    output logic                             e_valid,
    output rv32_pkg::kind_t                  e_kind,
    output logic [rv32_pkg::reg_id_bits-1:0] e_rd,
    output logic [rv32_pkg::xlen-1:0]        e_result,
    output logic [rv32_pkg::xlen-1:0]        e_store_data
);

    logic [rv32_pkg::xlen-1:0] op_a;
    logic [rv32_pkg::xlen-1:0] op_b;
    logic [rv32_pkg::xlen-1:0] alu_b;
    logic [rv32_pkg::xlen-1:0] alu_out;
    logic                      taken;

    // Younger result wins and load data only comes from writeback
    function automatic logic [rv32_pkg::xlen-1:0] forward(
        input logic [rv32_pkg::reg_id_bits-1:0] rs,
        input logic [rv32_pkg::xlen-1:0]        val
    );
        if (rs != '0 && e_valid && e_kind != rv32_pkg::KIND_LOAD && e_rd == rs) begin
            return e_result;
        end
        if (rs != '0 && wb_valid && wb_rd == rs) begin
            return wb_data;
        end
        return val;
    endfunction

    always_comb begin
        op_a = forward(d_rs1, d_a);
        op_b = forward(d_rs2, d_b);
    end
    // Stores add the offset while rs2 carries the data
    assign alu_b = (d_kind == rv32_pkg::KIND_STORE) ? d_imm : op_b;

    always_comb begin
        case (d_alu_op)
            rv32_pkg::ALU_SUB: alu_out = op_a - alu_b;
            rv32_pkg::ALU_AND: alu_out = op_a & alu_b;
            rv32_pkg::ALU_OR: alu_out = op_a | alu_b;
            rv32_pkg::ALU_XOR: alu_out = op_a ^ alu_b;
            rv32_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            rv32_pkg::ALU_PASS_B: alu_out = alu_b;
            default: alu_out = op_a + alu_b;
        endcase
    end

    always_comb begin
        case (d_kind)
            rv32_pkg::KIND_BRANCH_EQ: taken = (op_a == op_b);
            rv32_pkg::KIND_BRANCH_NE: taken = (op_a != op_b);
            rv32_pkg::KIND_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Only redirect when the pipe actually moves
    assign take_jump = d_valid && taken && !hold;
    assign jump_addr = d_pc + d_imm;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            e_valid <= 1'b0;
        end else if (!hold) begin
            e_valid <= d_valid;
            e_kind <= d_kind;
            e_rd <= d_rd;
            // JAL links pc plus 4
            e_result <= (d_kind == rv32_pkg::KIND_JUMP) ? d_pc + 32'd4 : alu_out;
            e_store_data <= op_b;
        end
    end

endmodule

`default_nettype wire

// File: source/rv32_mem_stage.sv
// Word accesses only; the request stays up until data_done
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_stage (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              e_valid,
    input  var   rv32_pkg::kind_t            e_kind,
    input  wire  [rv32_pkg::reg_id_bits-1:0] e_rd,
    input  wire  [rv32_pkg::xlen-1:0]        e_result,
    input  wire  [rv32_pkg::xlen-1:0]        e_store_data,
    output logic [rv32_pkg::xlen-1:0]        data_addr,
    output logic                             data_read,
    output logic                             data_write,
    output logic [rv32_pkg::xlen-1:0]        data_wdata,
    input  wire                              data_done,
    output logic                             mem_stall,
    output logic                             m_valid,
    output logic                             m_is_load,
    output logic [rv32_pkg::reg_id_bits-1:0] m_rd,
    output logic [rv32_pkg::xlen-1:0]        m_result
);

    logic is_load;
    logic is_store;

    assign is_load = e_valid && e_kind == rv32_pkg::KIND_LOAD;
    assign is_store = e_valid && e_kind == rv32_pkg::KIND_STORE;

    // Straight from the exec/mem buffer, stable while stalled
    assign data_addr = e_result;
    assign data_wdata = e_store_data;
    assign data_read = is_load;
    assign data_write = is_store;
    assign mem_stall = (is_load || is_store) && !data_done;

    // Frozen while stalled so writeback forwarding stays valid
    always_ff @(posedge clk) begin
        if (!resetn) begin
            m_valid <= 1'b0;
        end else if (!mem_stall) begin
            m_valid <= e_valid;
            m_is_load <= is_load;
            m_rd <= e_rd;
            m_result <= e_result;
        end
    end

endmodule

`default_nettype wire

// File: source/rv32_core.sv
// Five-stage in-order core; instruction and data ports each allow one access at a time
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
    input  wire                        clk,
    input  wire                        resetn,
    output logic [rv32_pkg::xlen-1:0] instr_addr,
    output logic                       instr_read,
    input  wire                        instr_done,
    input  wire  [rv32_pkg::xlen-1:0] instr,
    output logic [rv32_pkg::xlen-1:0] data_addr,
    output logic                       data_read,
    output logic                       data_write,
    output logic [rv32_pkg::xlen-1:0] data_wdata,
    input  wire                        data_done,
    input  wire  [rv32_pkg::xlen-1:0] data_rdata
);

    logic [rv32_pkg::xlen-1:0]        pc;
    logic                             flush;
    logic                             front_hold;
    logic                             fetch_stall;
    logic                             dec_stall;
    logic                             mem_stall;
    logic                             take_jump;
    logic [rv32_pkg::xlen-1:0]        jump_addr;
    logic [rv32_pkg::reg_id_bits-1:0] rs1;
    logic [rv32_pkg::reg_id_bits-1:0] rs2;
    logic [rv32_pkg::xlen-1:0]        reg1;
    logic [rv32_pkg::xlen-1:0]        reg2;
    logic                             f_valid;
    logic [rv32_pkg::xlen-1:0]        f_pc;
    logic [rv32_pkg::xlen-1:0]        f_instr;
    logic                             d_valid;
    logic [rv32_pkg::xlen-1:0]        d_pc;
    rv32_pkg::kind_t                  d_kind;
    rv32_pkg::alu_op_t                d_alu_op;
    logic [rv32_pkg::reg_id_bits-1:0] d_rs1;
    logic [rv32_pkg::reg_id_bits-1:0] d_rs2;
    logic [rv32_pkg::reg_id_bits-1:0] d_rd;
    logic [rv32_pkg::xlen-1:0]        d_a;
    logic [rv32_pkg::xlen-1:0]        d_b;
    logic [rv32_pkg::xlen-1:0]        d_imm;
    logic                             e_valid;
    rv32_pkg::kind_t                  e_kind;
    logic [rv32_pkg::reg_id_bits-1:0] e_rd;
    logic [rv32_pkg::xlen-1:0]        e_result;
    logic [rv32_pkg::xlen-1:0]        e_store_data;
    logic                             m_valid;
    logic                             m_is_load;
    logic [rv32_pkg::reg_id_bits-1:0] m_rd;
    logic [rv32_pkg::xlen-1:0]        m_result;
    logic [rv32_pkg::xlen-1:0]        load_data;
    logic [rv32_pkg::xlen-1:0]        wb_data;
    logic                             wb_write;

    // Redirect kills whatever fetch and decode hold this cycle
    assign flush = take_jump;
    assign front_hold = dec_stall || mem_stall;

    // Jump beats any stall, PC moves only when fetch hands a word on
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= rv32_pkg::reset_pc;
        end else if (take_jump) begin
            pc <= jump_addr;
        end else if (!(fetch_stall || front_hold)) begin
            pc <= pc + 32'd4;
        end
    end

    // Read data is only valid in the done cycle
    always_ff @(posedge clk) begin
        if (data_read && data_done) begin
            load_data <= data_rdata;
        end
    end

    // Writeback select
    assign wb_data = m_is_load ? load_data : m_result;
    assign wb_write = m_valid && m_rd != '0;

    rv32_register_file u_regs (
        .clk(clk), .resetn(resetn),
        .rs1(rs1), .rs2(rs2), .reg1(reg1), .reg2(reg2),
        .write(wb_write), .rd(m_rd), .wdata(wb_data)
    );

    rv32_fetch_stage u_fetch (
        .clk(clk), .resetn(resetn),
        .pc(pc), .hold(front_hold), .flush(flush),
        .instr_addr(instr_addr), .instr_read(instr_read),
        .instr_done(instr_done), .instr(instr),
        .fetch_stall(fetch_stall),
        .f_valid(f_valid), .f_pc(f_pc), .f_instr(f_instr)
    );

    rv32_decode_stage u_decode (
        .clk(clk), .resetn(resetn),
        .hold(mem_stall), .flush(flush),
        .f_valid(f_valid), .f_pc(f_pc), .f_instr(f_instr),
        .rs1(rs1), .rs2(rs2), .reg1(reg1), .reg2(reg2),
        .dec_stall(dec_stall),
        .d_valid(d_valid), .d_pc(d_pc), .d_kind(d_kind), .d_alu_op(d_alu_op),
        .d_rs1(d_rs1), .d_rs2(d_rs2), .d_rd(d_rd),
        .d_a(d_a), .d_b(d_b), .d_imm(d_imm)
    );

    rv32_exec_stage u_exec (
        .clk(clk), .resetn(resetn), .hold(mem_stall),
        .d_valid(d_valid), .d_pc(d_pc), .d_kind(d_kind), .d_alu_op(d_alu_op),
        .d_rs1(d_rs1), .d_rs2(d_rs2), .d_rd(d_rd),
        .d_a(d_a), .d_b(d_b), .d_imm(d_imm),
        .wb_valid(wb_write), .wb_rd(m_rd), .wb_data(wb_data),
        .take_jump(take_jump), .jump_addr(jump_addr),
        .e_valid(e_valid), .e_kind(e_kind), .e_rd(e_rd),
        .e_result(e_result), .e_store_data(e_store_data)
    );

    rv32_mem_stage u_mem (
        .clk(clk), .resetn(resetn),
        .e_valid(e_valid), .e_kind(e_kind), .e_rd(e_rd),
        .e_result(e_result), .e_store_data(e_store_data),
        .data_addr(data_addr), .data_read(data_read), .data_write(data_write),
        .data_wdata(data_wdata), .data_done(data_done),
        .mem_stall(mem_stall),
        .m_valid(m_valid), .m_is_load(m_is_load), .m_rd(m_rd), .m_result(m_result)
    );

endmodule

`default_nettype wire

// File: testbench/rv32_core_tb.sv
// Memories answer in 1 to 3 cycles; data space is 0x100..0x1FF; words past the program read 0
`timescale 1ns/1ps
`default_nettype none

module rv32_core_tb;

    localparam int imem_words = 64;
    localparam int dmem_words = 64;
    localparam int max_stores = 32;
    localparam int drain_cycles = 20;
    localparam logic [31:0] dmem_base = 32'h0000_0100;

    logic        clk;
    logic        resetn;
    logic [31:0] instr_addr;
    logic        instr_read;
    logic        instr_done;
    logic [31:0] instr;
    logic [31:0] data_addr;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_wdata;
    logic        data_done;
    logic [31:0] data_rdata;

    // Raw vector file and the split views
    logic [31:0] vectors [0:255];
    logic [31:0] imem [0:imem_words-1];
    logic [31:0] dmem [0:dmem_words-1];
    logic [31:0] exp_addr [0:max_stores-1];
    logic [31:0] exp_data [0:max_stores-1];
    int          prog_len;
    int          store_count;
    int          stores_seen;
    int          cycle;
    int          cycle_limit;
    int          quiet;
    // Cycles left until done or zero when idle
    int          instr_wait;
    int          data_wait;
    logic [31:0] instr_req_addr;
    logic [31:0] data_req_addr;
    logic        first_fetch;
    integer      seed;

    rv32_core i_dut (
        .clk(clk),
        .resetn(resetn),
        .instr_addr(instr_addr),
        .instr_read(instr_read),
        .instr_done(instr_done),
        .instr(instr),
        .data_addr(data_addr),
        .data_read(data_read),
        .data_write(data_write),
        .data_wdata(data_wdata),
        .data_done(data_done),
        .data_rdata(data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    // One access takes 1 to 3 cycles
    function automatic int pick_delay();
        return 1 + int'($unsigned($random(seed)) % 32'd3);
    endfunction

    function automatic logic in_data_range(input logic [31:0] addr);
        return addr >= dmem_base && addr < dmem_base + 32'(4 * dmem_words)
            && addr[1:0] == 2'b00;
    endfunction

    task automatic load_vectors();
        int base;
        $readmemh("testbench/rv32_core_vectors.txt", vectors);
        prog_len = int'(vectors[0]);
        store_count = int'(vectors[prog_len + 1]);
        if (prog_len < 1 || prog_len > imem_words) begin
            abort_run("The vector file holds a bad program length");
        end else if (store_count < 1 || store_count > max_stores) begin
            abort_run("The vector file holds a bad store count");
        end else begin
            for (int i = 0; i < imem_words; i++) begin
                imem[i] = (i < prog_len) ? vectors[i + 1] : 32'h0;
            end
            base = prog_len + 2;
            for (int i = 0; i < store_count; i++) begin
                exp_addr[i] = vectors[base + 2 * i];
                exp_data[i] = vectors[base + 2 * i + 1];
            end
        end
    endtask

    // Each word differs, so a wrong load address shows up
    task automatic fill_data_memory();
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = 32'hDA7A_0000 ^ (dmem_base + 32'(4 * i));
        end
    endtask

    task automatic record_store(input logic [31:0] addr, input logic [31:0] value);
        if (stores_seen >= store_count) begin
            abort_run($sformatf("The core wrote 0x%08h to 0x%08h after the last expected store",
                                value, addr));
        end else begin
            check_value($sformatf("store %0d address", stores_seen),
                        exp_addr[stores_seen], addr);
            check_value($sformatf("store %0d data", stores_seen),
                        exp_data[stores_seen], value);
            stores_seen++;
        end
    endtask

    task automatic serve_instr();
        instr_done = 1'b0;
        if (instr_read) begin
            if (instr_wait == 0) begin
                // New request
                if (first_fetch) begin
                    check_value("first fetch address", 32'h0, instr_addr);
                    first_fetch = 1'b0;
                end
                instr_req_addr = instr_addr;
                instr_wait = pick_delay();
            end else begin
                check_value("instruction address hold", instr_req_addr, instr_addr);
                instr_wait--;
                if (instr_wait == 0) begin
                    if (instr_req_addr < 32'(4 * imem_words)) begin
                        instr = imem[int'(instr_req_addr >> 2)];
                    end else begin
                        instr = 32'h0;
                    end
                    instr_done = 1'b1;
                end
            end
        end
    endtask

    task automatic serve_data();
        int idx;
        data_done = 1'b0;
        check_value("data read and write together", 32'h0, {31'b0, data_read && data_write});
        if (data_read || data_write) begin
            if (data_wait == 0) begin
                if (!in_data_range(data_addr)) begin
                    abort_run($sformatf("The core accessed 0x%08h outside the data memory",
                                        data_addr));
                end else begin
                    data_req_addr = data_addr;
                    data_wait = pick_delay();
                end
            end else begin
                check_value("data address hold", data_req_addr, data_addr);
                data_wait--;
                if (data_wait == 0) begin
                    idx = int'((data_req_addr - dmem_base) >> 2);
                    if (data_write) begin
                        record_store(data_req_addr, data_wdata);
                        dmem[idx] = data_wdata;
                    end else begin
                        data_rdata = dmem[idx];
                    end
                    data_done = 1'b1;
                end
            end
        end
    endtask

    initial begin
        seed = 95;
        resetn = 1'b0;
        instr_done = 1'b0;
        instr = 32'h0;
        data_done = 1'b0;
        data_rdata = 32'h0;
        instr_wait = 0;
        data_wait = 0;
        stores_seen = 0;
        cycle = 0;
        quiet = 0;
        first_fetch = 1'b1;
        load_vectors();
        fill_data_memory();
        // Generous budget per instruction and per store
        cycle_limit = 40 * (prog_len + store_count);
        // No request may leave the core while in reset
        repeat (16) begin
            @(posedge clk);
            #1;
            check_value("instr_read in reset", 32'h0, {31'b0, instr_read});
            check_value("data_read in reset", 32'h0, {31'b0, data_read});
            check_value("data_write in reset", 32'h0, {31'b0, data_write});
        end
        resetn = 1'b1;
        // Keep serving past the last store to catch extra writes
        while (quiet < drain_cycles) begin
            @(posedge clk);
            #1;
            cycle++;
            if (cycle > cycle_limit) begin
                abort_run($sformatf("Timeout: the core stopped making progress after %0d cycles",
                                    cycle_limit));
            end else begin
                serve_instr();
                serve_data();
                if (stores_seen == store_count) begin
                    quiet++;
                end
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/rv32_core_vectors.txt
// Word count, then one program word per line, then store count, then address and data pairs
// Trailing comments give the assembly of each program word
0000002D
10000093 // addi x1, x0, 0x100   data base
01900113 // addi x2, x0, 25
FFA00193 // addi x3, x0, -6
00310233 // add  x4, x2, x3
403102B3 // sub  x5, x2, x3
00317333 // and  x6, x2, x3
003163B3 // or   x7, x2, x3
00314433 // xor  x8, x2, x3
0021A4B3 // slt  x9, x3, x2
00312533 // slt  x10, x2, x3
123455B7 // lui  x11, 0x12345
67858593 // addi x11, x11, 0x678
0040A023 // sw   x4, 0(x1)
0050A223 // sw   x5, 4(x1)
0060A423 // sw   x6, 8(x1)
0070A623 // sw   x7, 12(x1)
0080A823 // sw   x8, 16(x1)
0090AA23 // sw   x9, 20(x1)
00A0AC23 // sw   x10, 24(x1)
00B0AE23 // sw   x11, 28(x1)
00110613 // addi x12, x2, 1
00C60633 // add  x12, x12, x12
40260633 // sub  x12, x12, x2
02C0A023 // sw   x12, 32(x1)
06300013 // addi x0, x0, 99
0200A223 // sw   x0, 36(x1)
0000A703 // lw   x14, 0(x1)
002707B3 // add  x15, x14, x2
02F0A423 // sw   x15, 40(x1)
0040A803 // lw   x16, 4(x1)
0300A623 // sw   x16, 44(x1)
00000893 // addi x17, x0, 0
00310463 // beq  x2, x3, +8      not taken
00188893 // addi x17, x17, 1
00210463 // beq  x2, x2, +8      taken
01088893 // addi x17, x17, 16    skipped
00211463 // bne  x2, x2, +8      not taken
00288893 // addi x17, x17, 2
00311463 // bne  x2, x3, +8      taken
02088893 // addi x17, x17, 32    skipped
0080096F // jal  x18, +8
04088893 // addi x17, x17, 64    skipped
0310A823 // sw   x17, 48(x1)
0320AA23 // sw   x18, 52(x1)
0000006F // jal  x0, 0           park
0000000E
00000100 00000013 // 25 + -6
00000104 0000001F // 25 - -6
00000108 00000018 // and
0000010C FFFFFFFB // or
00000110 FFFFFFE3 // xor
00000114 00000001 // -6 < 25
00000118 00000000 // 25 < -6
0000011C 12345678 // lui then addi
00000120 0000001B // (26 + 26) - 25
00000124 00000000 // x0 stays zero
00000128 0000002C // loaded 19 + 25
0000012C 0000001F // loaded 31 stored right away
00000130 00000003 // only the untaken paths add
00000134 000000A4 // jal link

// File: vlog.f
source/rv32_pkg.sv
source/rv32_register_file.sv
source/rv32_fetch_stage.sv
source/rv32_decode_stage.sv
source/rv32_exec_stage.sv
source/rv32_mem_stage.sv
source/rv32_core.sv
testbench/rv32_core_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; exit status follows the pass message
cd "$(dirname "$0")" \
    && verilator --binary -j 0 --timescale 1ns/1ps --top-module rv32_core_tb \
        -f vlog.f -o rv32_core_sim \
    && ./obj_dir/rv32_core_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
